// File: verilog/event_defs.svh
`ifndef EVENT_DEFS_SVH
`define EVENT_DEFS_SVH

//////////////////////////////////////////////////
// event front end sizing
//////////////////////////////////////////////////

// number of incoming links
`define NUM_LINKS 4

// dword width of one link
`define LINK_DATA_W 32

// wishbone byte address width
`define WB_ADR_W 15

// entries in every stream FIFO
`define FIFO_DEPTH 16

`endif

// File: verilog/event_pkg.sv
`default_nettype none

`include "event_defs.svh"

package event_pkg;

    // one link dword
    typedef logic [`LINK_DATA_W-1:0] link_data_t;

    // link beat, dword plus end of frame
    typedef struct packed {
        link_data_t data;
        logic       last;
    } link_word_t;

    typedef logic [$clog2(`NUM_LINKS)-1:0] lane_id_t;

    // merged output beat tagged with its source lane
    typedef struct packed {
        link_word_t word;
        lane_id_t   lane;
    } event_word_t;

    // set bit = link masked
    typedef logic [`NUM_LINKS-1:0] lane_mask_t;

    typedef logic [31:0] dword_count_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

endpackage

`default_nettype wire

// File: verilog/link_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface link_stream_if;
    import event_pkg::*;

    // beat moves on an edge with valid and ready both high
    link_word_t word;
    logic       valid;
    logic       ready;

    // source holds word steady while valid waits for ready
    modport source (
        output word,
        output valid,
        input  ready
    );

    modport sink (
        input  word,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: verilog/link_gate.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module link_gate (
    input  wire                                      aclk,
    input  wire                                      reset_i,
    input  wire                                      event_open_i,
    input  event_pkg::link_data_t [`NUM_LINKS-1:0]   s_data_i,
    input  wire [`NUM_LINKS-1:0]                     s_last_i,
    input  wire [`NUM_LINKS-1:0]                     s_valid_i,
    output logic [`NUM_LINKS-1:0]                    s_ready_o,
    link_stream_if.source                            out [`NUM_LINKS]
);
    import event_pkg::*;

    logic open_q;

    // window flag, gating follows event_open_i one cycle late
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            open_q <= 1'b0;
        end else begin
            open_q <= event_open_i;
        end
    end

    //////////////////////////////////////////////////
    // per lane gating
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `NUM_LINKS; g++) begin : g_lane
        assign out[g].word  = '{data: s_data_i[g], last: s_last_i[g]};
        assign out[g].valid = s_valid_i[g] && open_q;
        // closed window swallows everything the link offers
        assign s_ready_o[g] = out[g].ready || !open_q;
    end

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FIFO_DEPTH
) (
    input  wire      aclk,
    input  wire      reset_i,
    input  payload_t wr_data_i,
    input  wire      wr_valid_i,
    output logic     wr_ready_o,
    output payload_t rd_data_o,
    output logic     rd_valid_o,
    input  wire      rd_ready_i
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready_o = (count != CNT_W'(DEPTH));
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    // storage
    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // pointers wrap at DEPTH so any depth works
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/link_channel.sv
`timescale 1ns/1ps
`default_nettype none

module link_channel (
    input  wire                     aclk,
    input  wire                     reset_i,
    input  wire                     clear_i,
    link_stream_if.sink             in,
    link_stream_if.source           out,
    output event_pkg::dword_count_t dword_count_o
);
    import event_pkg::*;

    dword_count_t count_q;
    logic         accept;

    assign accept        = in.valid && in.ready;
    assign dword_count_o = count_q;

    //////////////////////////////////////////////////
    // frame buffer
    //////////////////////////////////////////////////
    stream_fifo #(
        .payload_t (link_word_t)
    ) u_fifo (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .wr_data_i  (in.word),
        .wr_valid_i (in.valid),
        .wr_ready_o (in.ready),
        .rd_data_o  (out.word),
        .rd_valid_o (out.valid),
        .rd_ready_i (out.ready)
    );

    //////////////////////////////////////////////////
    // accepted dword statistics
    //////////////////////////////////////////////////

    // wraps on overflow, held at zero during clear
    always_ff @(posedge aclk) begin
        if (reset_i || clear_i) begin
            count_q <= '0;
        end else if (accept) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/event_merger.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module event_merger (
    input  wire                    aclk,
    input  wire                    reset_i,
    input  event_pkg::lane_mask_t  lane_mask_i,
    link_stream_if.sink            in [`NUM_LINKS],
    output event_pkg::link_data_t  m_data_o,
    output logic                   m_last_o,
    output event_pkg::lane_id_t    m_lane_o,
    output logic                   m_valid_o,
    input  wire                    m_ready_i
);
    import event_pkg::*;

    link_word_t            lane_word  [`NUM_LINKS];
    logic [`NUM_LINKS-1:0] lane_valid;
    logic [`NUM_LINKS-1:0] lane_ready;

    lane_id_t    lane_q;
    link_word_t  cur_word;
    logic        cur_valid;
    logic        cur_masked;
    logic        later_unmasked;
    logic        take;
    logic        fifo_wr_ready;
    event_word_t fifo_wr_data;
    event_word_t fifo_rd_data;

    //////////////////////////////////////////////////
    // flatten the link array
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `NUM_LINKS; g++) begin : g_lane
        assign lane_word[g]  = in[g].word;
        assign lane_valid[g] = in[g].valid;
        // only the current lane is read; masked lanes drain freely
        assign lane_ready[g] = (lane_q == lane_id_t'(g)) && (lane_mask_i[g] || fifo_wr_ready);
        assign in[g].ready   = lane_ready[g];
    end

    assign cur_word   = lane_word[lane_q];
    assign cur_valid  = lane_valid[lane_q];
    assign cur_masked = lane_mask_i[lane_q];
    assign take       = cur_valid && lane_ready[lane_q];

    // does an unmasked lane still follow in this event
    always_comb begin
        later_unmasked = 1'b0;
        for (int i = 0; i < `NUM_LINKS; i++) begin
            if (i > int'(lane_q) && !lane_mask_i[i]) begin
                later_unmasked = 1'b1;
            end
        end
    end

    // event last only on the final unmasked frame
    assign fifo_wr_data = '{
        word: '{data: cur_word.data, last: cur_word.last && !later_unmasked},
        lane: lane_q
    };

    // lane pointer walks 0..3 and wraps for the next event
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            lane_q <= '0;
        end else if (take && cur_word.last) begin
            lane_q <= lane_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // output buffer
    //////////////////////////////////////////////////
    stream_fifo #(
        .payload_t (event_word_t)
    ) u_out_fifo (
        .aclk       (aclk),
        .reset_i    (reset_i),
        .wr_data_i  (fifo_wr_data),
        .wr_valid_i (cur_valid && !cur_masked),
        .wr_ready_o (fifo_wr_ready),
        .rd_data_o  (fifo_rd_data),
        .rd_valid_o (m_valid_o),
        .rd_ready_i (m_ready_i)
    );

    assign m_data_o = fifo_rd_data.word.data;
    assign m_last_o = fifo_rd_data.word.last;
    assign m_lane_o = fifo_rd_data.lane;

endmodule

`default_nettype wire

// File: verilog/event_regs_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module event_regs_wb (
    input  wire                                      aclk,
    input  wire                                      reset_i,
    input  wire                                      wb_cyc_i,
    input  wire                                      wb_stb_i,
    input  wire                                      wb_we_i,
    input  wire [`WB_ADR_W-1:0]                      wb_adr_i,
    input  event_pkg::wb_data_t                      wb_dat_i,
    input  event_pkg::wb_sel_t                       wb_sel_i,
    output event_pkg::wb_data_t                      wb_dat_o,
    output logic                                     wb_ack_o,
    input  event_pkg::dword_count_t [`NUM_LINKS-1:0] dword_count_i,
    output logic                                     event_reset_o,
    output event_pkg::lane_mask_t                    lane_mask_o
);
    import event_pkg::*;

    logic       ack_q;
    wb_data_t   dat_q;
    logic       event_reset_q;
    lane_mask_t mask_q;
    logic       start;
    logic [2:0] word_adr;
    wb_data_t   rd_value;

    // new access seen, ack goes out on this edge
    assign start    = wb_cyc_i && wb_stb_i && !ack_q;
    // address bit 5 ignored, upper half mirrors the lower
    assign word_adr = wb_adr_i[4:2];

    assign wb_ack_o      = ack_q;
    assign wb_dat_o      = dat_q;
    assign event_reset_o = event_reset_q;
    assign lane_mask_o   = mask_q;

    //////////////////////////////////////////////////
    // read decode
    //////////////////////////////////////////////////
    always_comb begin
        rd_value = '0;
        if (!word_adr[2]) begin
            // control word at 0-3
            rd_value[0]    = event_reset_q;
            rd_value[11:8] = mask_q;
        end else begin
            rd_value = dword_count_i[word_adr[1:0]];
        end
    end

    always_ff @(posedge aclk) begin
        if (start && !wb_we_i) begin
            dat_q <= rd_value;
        end
    end

    //////////////////////////////////////////////////
    // handshake and control writes
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            ack_q         <= 1'b0;
            event_reset_q <= 1'b0;
            mask_q        <= '0;
        end else begin
            ack_q <= start;
            if (start && wb_we_i && !word_adr[2]) begin
                if (wb_sel_i[0]) begin
                    event_reset_q <= wb_dat_i[0];
                end
                if (wb_sel_i[1]) begin
                    mask_q <= wb_dat_i[11:8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/event_readout_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module event_readout_top (
    input  wire                                      aclk,
    input  wire                                      reset_i,
    input  wire                                      event_open_i,
    // link inputs
    input  event_pkg::link_data_t [`NUM_LINKS-1:0]   s_data_i,
    input  wire [`NUM_LINKS-1:0]                     s_last_i,
    input  wire [`NUM_LINKS-1:0]                     s_valid_i,
    output logic [`NUM_LINKS-1:0]                    s_ready_o,
    // merged event stream
    output event_pkg::link_data_t                    m_data_o,
    output logic                                     m_last_o,
    output event_pkg::lane_id_t                      m_lane_o,
    output logic                                     m_valid_o,
    input  wire                                      m_ready_i,
    // wishbone
    input  wire                                      wb_cyc_i,
    input  wire                                      wb_stb_i,
    input  wire                                      wb_we_i,
    input  wire [`WB_ADR_W-1:0]                      wb_adr_i,
    input  event_pkg::wb_data_t                      wb_dat_i,
    input  event_pkg::wb_sel_t                       wb_sel_i,
    output event_pkg::wb_data_t                      wb_dat_o,
    output logic                                     wb_ack_o
);
    import event_pkg::*;

    link_stream_if gate_if [`NUM_LINKS] ();
    link_stream_if chan_if [`NUM_LINKS] ();

    dword_count_t [`NUM_LINKS-1:0] dword_count;
    lane_mask_t                    lane_mask;
    logic                          event_reset;
    logic                          core_rst;

    // event reset clears the datapath but not the registers
    assign core_rst = reset_i || event_reset;

    link_gate u_gate (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .event_open_i (event_open_i),
        .s_data_i     (s_data_i),
        .s_last_i     (s_last_i),
        .s_valid_i    (s_valid_i),
        .s_ready_o    (s_ready_o),
        .out          (gate_if)
    );

    //////////////////////////////////////////////////
    // per link buffering
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `NUM_LINKS; g++) begin : g_chan
        link_channel u_channel (
            .aclk          (aclk),
            .reset_i       (core_rst),
            .clear_i       (event_reset),
            .in            (gate_if[g]),
            .out           (chan_if[g]),
            .dword_count_o (dword_count[g])
        );
    end

    event_merger u_merger (
        .aclk        (aclk),
        .reset_i     (core_rst),
        .lane_mask_i (lane_mask),
        .in          (chan_if),
        .m_data_o    (m_data_o),
        .m_last_o    (m_last_o),
        .m_lane_o    (m_lane_o),
        .m_valid_o   (m_valid_o),
        .m_ready_i   (m_ready_i)
    );

    event_regs_wb u_regs (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .dword_count_i (dword_count),
        .event_reset_o (event_reset),
        .lane_mask_o   (lane_mask)
    );

endmodule

`default_nettype wire

// File: tests/tb_event_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "event_defs.svh"

module tb_event_readout;
    import event_pkg::*;

    localparam int MAX_WAIT = 400;

    logic                        aclk;
    logic                        reset_i;
    logic                        event_open_i;
    link_data_t [`NUM_LINKS-1:0] s_data_i;
    logic [`NUM_LINKS-1:0]       s_last_i;
    logic [`NUM_LINKS-1:0]       s_valid_i;
    logic [`NUM_LINKS-1:0]       s_ready_o;
    link_data_t                  m_data_o;
    logic                        m_last_o;
    lane_id_t                    m_lane_o;
    logic                        m_valid_o;
    logic                        m_ready_i;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_we_i;
    logic [`WB_ADR_W-1:0]        wb_adr_i;
    wb_data_t                    wb_dat_i;
    wb_sel_t                     wb_sel_i;
    wb_data_t                    wb_dat_o;
    logic                        wb_ack_o;

    int          errors;
    int          checks;
    int          tests_run;
    int          errors_at_start;
    logic        stalled;
    logic        window_open;
    logic        bp_done;
    lane_mask_t  cur_mask;
    int          sent_cnt [`NUM_LINKS];
    event_word_t exp_q [$];

    event_readout_top dut_i (.*);

    always #20 aclk = ~aclk;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_reg(input string name, input wb_data_t exp, input wb_data_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    task automatic check_flags(input string name, input logic [`NUM_LINKS-1:0] exp,
                               input logic [`NUM_LINKS-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_beat(input event_word_t exp, input event_word_t got);
        checks++;
        if (got.word.data !== exp.word.data) begin
            $display("[ERROR] m_data_o expected 0x%08h got 0x%08h", exp.word.data, got.word.data);
        end
        if (got.word.last !== exp.word.last) begin
            $display("[ERROR] m_last_o expected 0x%h got 0x%h", exp.word.last, got.word.last);
        end
        if (got.lane !== exp.lane) begin
            $display("[ERROR] m_lane_o expected 0x%h got 0x%h", exp.lane, got.lane);
        end
        if (got !== exp) begin
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        stalled = 1'b1;
        $display("timeout, no response while waiting for %s", what);
    endtask

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge aclk);
        #2;
    endtask

    function automatic logic [`WB_ADR_W-1:0] reg_adr(input int word);
        return `WB_ADR_W'(word * 4);
    endfunction

    task automatic wb_access(input logic [`WB_ADR_W-1:0] adr, input logic we,
                             input wb_data_t wdat, input wb_sel_t sel, output wb_data_t rdat);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        rdat     = '0;
        waited   = 0;
        @(negedge aclk);
        while (!wb_ack_o && waited < MAX_WAIT) begin
            waited++;
            @(negedge aclk);
        end
        if (wb_ack_o) begin
            rdat = wb_dat_o;
        end else begin
            report_timeout($sformatf("wishbone ack at address 0x%h", adr));
        end
        next_cycle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input int word, input wb_data_t data, input wb_sel_t sel);
        wb_data_t unused;
        wb_access(reg_adr(word), 1'b1, data, sel, unused);
    endtask

    task automatic wb_read(input int word, output wb_data_t data);
        wb_access(reg_adr(word), 1'b0, '0, 4'hf, data);
    endtask

    task automatic read_check(input int word, input wb_data_t exp);
        wb_data_t got;
        wb_read(word, got);
        check_reg($sformatf("wb_dat_o[word %0d]", word), exp, got);
    endtask

    // gating follows the flag one cycle late
    task automatic set_window(input logic open);
        event_open_i = open;
        window_open  = open;
        next_cycle();
    endtask

    // marker nibble, event, lane and beat index
    function automatic link_data_t beat_data(input int ev, input int lane, input int idx);
        return {4'ha, 4'(ev), 8'(lane), 16'(idx)};
    endfunction

    task automatic send_frame(input int lane, input int ev, input int len);
        int waited;
        for (int i = 0; i < len; i++) begin
            s_data_i[lane]  = beat_data(ev, lane, i);
            s_last_i[lane]  = (i == len - 1);
            s_valid_i[lane] = 1'b1;
            waited = 0;
            @(negedge aclk);
            while (!s_ready_o[lane] && waited < MAX_WAIT) begin
                waited++;
                @(negedge aclk);
            end
            if (!s_ready_o[lane]) begin
                report_timeout($sformatf("s_ready_o on lane %0d", lane));
                s_valid_i[lane] = 1'b0;
                return;
            end
            if (window_open) begin
                sent_cnt[lane]++;
            end
            next_cycle();
        end
        s_valid_i[lane] = 1'b0;
        s_last_i[lane]  = 1'b0;
    endtask

    task automatic send_event(input int ev, input int lens [`NUM_LINKS]);
        for (int l = 0; l < `NUM_LINKS; l++) begin
            send_frame(l, ev, lens[l]);
        end
    endtask

    // lanes in ascending order, masked frames vanish, last on the top unmasked lane
    function automatic void queue_event(input int ev, input int lens [`NUM_LINKS]);
        int          top;
        event_word_t w;
        top = -1;
        for (int l = 0; l < `NUM_LINKS; l++) begin
            if (!cur_mask[l]) begin
                top = l;
            end
        end
        for (int l = 0; l < `NUM_LINKS; l++) begin
            for (int i = 0; i < lens[l] && !cur_mask[l]; i++) begin
                w.word.data = beat_data(ev, l, i);
                w.word.last = (l == top) && (i == lens[l] - 1);
                w.lane      = lane_id_t'(l);
                exp_q.push_back(w);
            end
        end
    endfunction

    task automatic expect_beat(input event_word_t exp);
        int          waited;
        event_word_t got;
        waited = 0;
        @(negedge aclk);
        while (!(m_valid_o && m_ready_i) && waited < MAX_WAIT) begin
            waited++;
            @(negedge aclk);
        end
        if (!(m_valid_o && m_ready_i)) begin
            report_timeout("an output beat");
            return;
        end
        got.word.data = m_data_o;
        got.word.last = m_last_o;
        got.lane      = m_lane_o;
        check_beat(exp, got);
        next_cycle();
    endtask

    task automatic drain_expected();
        while (exp_q.size() > 0 && !stalled) begin
            expect_beat(exp_q.pop_front());
        end
        exp_q.delete();
    endtask

    // output must stay quiet and every lane ready
    task automatic idle_watch(input int cycles);
        logic                  seen_valid;
        logic [`NUM_LINKS-1:0] ready_all;
        seen_valid = 1'b0;
        ready_all  = '1;
        for (int c = 0; c < cycles; c++) begin
            @(negedge aclk);
            seen_valid = seen_valid | m_valid_o;
            ready_all  = ready_all & s_ready_o;
            next_cycle();
        end
        check_flags("m_valid_o", '0, lane_mask_t'(seen_valid));
        check_flags("s_ready_o", '1, ready_all);
    endtask

    task automatic check_counters();
        for (int l = 0; l < `NUM_LINKS; l++) begin
            read_check(4 + l, wb_data_t'(sent_cnt[l]));
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        stalled         = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d error(s)", name, errors - errors_at_start);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic test_reset_defaults();
        begin_test();
        for (int w = 0; w < 16; w++) begin
            read_check(w, '0);
        end
        idle_watch(10);
        end_test("reset_defaults");
    endtask

    task automatic test_ordered_merge();
        int lens [`NUM_LINKS];
        begin_test();
        lens = '{3, 1, 2, 4};
        set_window(1'b1);
        queue_event(1, lens);
        fork
            send_event(1, lens);
            drain_expected();
        join
        idle_watch(8);
        end_test("ordered_merge");
    endtask

    task automatic test_masking();
        int lens_a [`NUM_LINKS];
        int lens_b [`NUM_LINKS];
        begin_test();
        lens_a = '{2, 3, 1, 2};
        lens_b = '{1, 2, 3, 1};
        wb_write(0, 32'h0000_0500, 4'b0010);
        cur_mask = 4'b0101;
        read_check(0, 32'h0000_0500);
        queue_event(2, lens_a);
        queue_event(3, lens_b);
        fork
            begin
                send_event(2, lens_a);
                send_event(3, lens_b);
            end
            drain_expected();
        join
        idle_watch(8);
        end_test("masking");
    endtask

    task automatic test_closed_window();
        int lens [`NUM_LINKS];
        begin_test();
        lens = '{2, 2, 2, 2};
        set_window(1'b0);
        fork
            send_event(4, lens);
            idle_watch(40);
        join
        check_counters();
        end_test("closed_window");
    endtask

    task automatic test_counters_reset();
        begin_test();
        check_counters();
        read_check(12, wb_data_t'(sent_cnt[0]));
        wb_write(0, 32'h0000_0001, 4'b0001);
        wb_write(0, 32'h0000_0000, 4'b0001);
        for (int l = 0; l < `NUM_LINKS; l++) begin
            sent_cnt[l] = 0;
        end
        check_counters();
        read_check(0, {20'h0, cur_mask, 8'h00});
        end_test("counters_reset");
    endtask

    task automatic test_back_pressure();
        int lens [4][`NUM_LINKS];
        int cycles;
        begin_test();
        wb_write(0, 32'h0000_0200, 4'b0010);
        cur_mask = 4'b0010;
        set_window(1'b1);
        for (int e = 0; e < 4; e++) begin
            for (int l = 0; l < `NUM_LINKS; l++) begin
                lens[e][l] = int'($urandom_range(6, 1));
            end
            queue_event(5 + e, lens[e]);
        end
        bp_done = 1'b0;
        cycles  = 0;
        fork
            for (int e = 0; e < 4; e++) begin
                send_event(5 + e, lens[e]);
            end
            begin
                drain_expected();
                bp_done = 1'b1;
            end
            while (!bp_done && cycles < 4000) begin
                m_ready_i = 1'($urandom_range(1, 0));
                next_cycle();
                cycles++;
            end
        join
        m_ready_i = 1'b1;
        idle_watch(8);
        check_counters();
        end_test("back_pressure");
    endtask

    initial begin
        void'($urandom(32'h8d8f4c5e));
        aclk         = 1'b0;
        reset_i      = 1'b1;
        event_open_i = 1'b0;
        s_data_i     = '0;
        s_last_i     = '0;
        s_valid_i    = '0;
        m_ready_i    = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        stalled      = 1'b0;
        window_open  = 1'b0;
        bp_done      = 1'b0;
        cur_mask     = '0;
        for (int l = 0; l < `NUM_LINKS; l++) begin
            sent_cnt[l] = 0;
        end

        repeat (2) @(posedge aclk);
        #2;
        reset_i = 1'b0;

        test_reset_defaults();
        test_ordered_merge();
        test_masking();
        test_closed_window();
        test_counters_reset();
        test_back_pressure();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/event_pkg.sv
verilog/link_stream_if.sv
verilog/link_gate.sv
verilog/stream_fifo.sv
verilog/link_channel.sv
verilog/event_merger.sv
verilog/event_regs_wb.sv
verilog/event_readout_top.sv
tests/tb_event_readout.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the event readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_event_readout
LOG=sim.log

verilator --binary --timing -j 0 --top-module "$TOP" -f filelist.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q -F '*** FAILED ***' "$LOG"; then
    exit 1
fi
exit 0
